/* logic/standby_macros.svh */
// Standby bus glue constants: data width, reset-action codes, owner count
`ifndef STANDBY_MACROS_SVH
`define STANDBY_MACROS_SVH

// Bus data width in bits
`define I3C_BYTE_W 8

// Reset-action code width as delivered by the CCC handler
`define RSTACT_W 8

// Reset-action codes
`define RSTACT_PERIPHERAL 8'h01
`define RSTACT_ESCALATE 8'h02

// Number of requesters that can own the bus
`define STANDBY_OWNERS 3

`endif

/* logic/i3c_bus_pkg.sv */
// I3C bus engine request payloads for the TX and RX flows
`include "standby_macros.svh"

package i3c_bus_pkg;

  // Request towards the TX engine
  typedef struct packed {
    logic                   req_byte;
    logic                   req_bit;
    logic [`I3C_BYTE_W-1:0] value;
    // 1 selects push-pull, 0 open-drain
    logic                   sel_od_pp;
  } bus_tx_req_t;

  // Request towards the RX engine
  typedef struct packed {
    logic req_bit;
    logic req_byte;
  } bus_rx_req_t;

endpackage

/* logic/standby_ctrl_pkg.sv */
// Standby controller bus ownership types
`include "standby_macros.svh"

package standby_ctrl_pkg;

  // Requesters sharing the bus engines
  typedef enum logic [$clog2(`STANDBY_OWNERS)-1:0] {
    OwnerFsm,
    OwnerCcc,
    OwnerIbi
  } bus_owner_e;

endpackage

/* logic/xfer_owner_ctrl.sv */
// Bus ownership FSM granting the engines to the target FSM, CCC or IBI handler
`timescale 1ns/1ps

module xfer_owner_ctrl
  import standby_ctrl_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       ccc_valid_i,
  input  logic       ccc_done_i,
  input  logic       ccc_next_i,
  input  logic       ibi_begin_i,
  input  logic       ibi_done_i,
  output bus_owner_e owner_o
);

  bus_owner_e owner_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      owner_q <= OwnerFsm;
    end else begin
      case (owner_q)
        OwnerFsm: begin
          // Both requests at once count as no request
          if (ccc_valid_i && !ibi_begin_i) begin
            owner_q <= OwnerCcc;
          end else if (ibi_begin_i && !ccc_valid_i) begin
            owner_q <= OwnerIbi;
          end
        end
        OwnerCcc: begin
          if (ccc_done_i || ccc_next_i) begin
            owner_q <= OwnerFsm;
          end
        end
        OwnerIbi: begin
          if (ibi_done_i) begin
            owner_q <= OwnerFsm;
          end
        end
        default: owner_q <= OwnerFsm;
      endcase
    end
  end

  assign owner_o = owner_q;

endmodule

/* logic/bus_req_mux.sv */
// Selects the current owner's request payload towards a bus engine
`timescale 1ns/1ps

module bus_req_mux
  import standby_ctrl_pkg::*;
#(
  parameter type payload_t = logic
) (
  input  bus_owner_e owner_i,
  input  payload_t   fsm_req_i,
  input  payload_t   ccc_req_i,
  input  payload_t   ibi_req_i,
  output payload_t   req_o
);

  always_comb begin
    case (owner_i)
      OwnerFsm: req_o = fsm_req_i;
      OwnerCcc: req_o = ccc_req_i;
      OwnerIbi: req_o = ibi_req_i;
      // Unused owner code drives no request
      default:  req_o = '0;
    endcase
  end

endmodule

/* logic/bus_rsp_route.sv */
// Routes bus engine results to the current owner and zeroes everyone else
`timescale 1ns/1ps
`include "standby_macros.svh"

module bus_rsp_route
  import standby_ctrl_pkg::*;
(
  input  bus_owner_e             owner_i,
  input  logic                   tx_done_i,
  input  logic                   tx_idle_i,
  input  logic                   tx_err_i,
  input  logic                   rx_done_i,
  input  logic                   rx_idle_i,
  input  logic                   rx_error_i,
  input  logic [`I3C_BYTE_W-1:0] rx_data_i,
  output logic                   fsm_tx_done_o,
  output logic                   fsm_tx_idle_o,
  output logic                   fsm_tx_err_o,
  output logic                   fsm_rx_done_o,
  output logic                   fsm_rx_idle_o,
  output logic                   fsm_rx_error_o,
  output logic [`I3C_BYTE_W-1:0] fsm_rx_data_o,
  output logic                   ccc_tx_done_o,
  output logic                   ccc_tx_idle_o,
  output logic                   ccc_tx_err_o,
  output logic                   ccc_rx_done_o,
  output logic                   ccc_rx_idle_o,
  output logic                   ccc_rx_error_o,
  output logic [`I3C_BYTE_W-1:0] ccc_rx_data_o,
  output logic                   ibi_tx_done_o,
  output logic                   ibi_rx_done_o,
  output logic [`I3C_BYTE_W-1:0] ibi_rx_data_o
);

  always_comb begin
    fsm_tx_done_o  = 1'b0;
    fsm_tx_idle_o  = 1'b0;
    fsm_tx_err_o   = 1'b0;
    fsm_rx_done_o  = 1'b0;
    fsm_rx_idle_o  = 1'b0;
    fsm_rx_error_o = 1'b0;
    fsm_rx_data_o  = '0;
    ccc_tx_done_o  = 1'b0;
    ccc_tx_idle_o  = 1'b0;
    ccc_tx_err_o   = 1'b0;
    ccc_rx_done_o  = 1'b0;
    ccc_rx_idle_o  = 1'b0;
    ccc_rx_error_o = 1'b0;
    ccc_rx_data_o  = '0;
    ibi_tx_done_o  = 1'b0;
    ibi_rx_done_o  = 1'b0;
    ibi_rx_data_o  = '0;

    case (owner_i)
      OwnerFsm: begin
        fsm_tx_done_o  = tx_done_i;
        fsm_tx_idle_o  = tx_idle_i;
        fsm_tx_err_o   = tx_err_i;
        fsm_rx_done_o  = rx_done_i;
        fsm_rx_idle_o  = rx_idle_i;
        fsm_rx_error_o = rx_error_i;
        fsm_rx_data_o  = rx_data_i;
      end
      OwnerCcc: begin
        ccc_tx_done_o  = tx_done_i;
        ccc_tx_idle_o  = tx_idle_i;
        ccc_tx_err_o   = tx_err_i;
        ccc_rx_done_o  = rx_done_i;
        ccc_rx_idle_o  = rx_idle_i;
        ccc_rx_error_o = rx_error_i;
        ccc_rx_data_o  = rx_data_i;
      end
      OwnerIbi: begin
        // IBI handler only sees completions and data
        ibi_tx_done_o = tx_done_i;
        ibi_rx_done_o = rx_done_i;
        ibi_rx_data_o = rx_data_i;
      end
      default: ;
    endcase
  end

endmodule

/* logic/reset_action_ctrl.sv */
// Peripheral and escalated reset requests from reset actions and reset patterns
`timescale 1ns/1ps
`include "standby_macros.svh"

module reset_action_ctrl (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic [`RSTACT_W-1:0] rst_action_i,
  input  logic                rst_action_valid_i,
  input  logic                target_reset_detect_i,
  input  logic                escalate_arm_i,
  input  logic                rstact_armed_i,
  input  logic                peripheral_reset_done_i,
  output logic                peripheral_reset_o,
  output logic                escalated_reset_o
);

  logic periph_trig;
  logic escal_trig;

  // First reset pattern resets the peripheral, the armed second one escalates
  assign periph_trig = (rst_action_valid_i && (rst_action_i == `RSTACT_PERIPHERAL)) ||
                       (target_reset_detect_i && !escalate_arm_i && !rstact_armed_i);
  assign escal_trig  = (rst_action_valid_i && (rst_action_i == `RSTACT_ESCALATE)) ||
                       (target_reset_detect_i && escalate_arm_i && !rstact_armed_i);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      peripheral_reset_o <= 1'b0;
    end else if (peripheral_reset_done_i) begin
      // Done wins over a new trigger
      peripheral_reset_o <= 1'b0;
    end else if (periph_trig) begin
      peripheral_reset_o <= 1'b1;
    end
  end

  // Sticky until the next controller reset
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      escalated_reset_o <= 1'b0;
    end else if (escal_trig) begin
      escalated_reset_o <= 1'b1;
    end
  end

endmodule

/* logic/standby_bus_top.sv */
// Standby target bus glue: engine ownership, request and result routing, reset actions
`timescale 1ns/1ps
`include "standby_macros.svh"

module standby_bus_top
  import i3c_bus_pkg::*;
  import standby_ctrl_pkg::*;
(
  input  logic                   clk_i,
  input  logic                   rst_ni,
  // Target FSM requests and results
  input  logic                   fsm_tx_req_byte_i,
  input  logic                   fsm_tx_req_bit_i,
  input  logic [`I3C_BYTE_W-1:0] fsm_tx_req_value_i,
  input  logic                   fsm_tx_sel_od_pp_i,
  input  logic                   fsm_rx_req_bit_i,
  input  logic                   fsm_rx_req_byte_i,
  output logic                   fsm_tx_done_o,
  output logic                   fsm_tx_idle_o,
  output logic                   fsm_tx_err_o,
  output logic                   fsm_rx_done_o,
  output logic                   fsm_rx_idle_o,
  output logic                   fsm_rx_error_o,
  output logic [`I3C_BYTE_W-1:0] fsm_rx_data_o,
  // CCC handler requests and results
  input  logic                   ccc_tx_req_byte_i,
  input  logic                   ccc_tx_req_bit_i,
  input  logic [`I3C_BYTE_W-1:0] ccc_tx_req_value_i,
  input  logic                   ccc_tx_sel_od_pp_i,
  input  logic                   ccc_rx_req_bit_i,
  input  logic                   ccc_rx_req_byte_i,
  output logic                   ccc_tx_done_o,
  output logic                   ccc_tx_idle_o,
  output logic                   ccc_tx_err_o,
  output logic                   ccc_rx_done_o,
  output logic                   ccc_rx_idle_o,
  output logic                   ccc_rx_error_o,
  output logic [`I3C_BYTE_W-1:0] ccc_rx_data_o,
  // IBI handler requests and results
  input  logic                   ibi_tx_req_byte_i,
  input  logic                   ibi_tx_req_bit_i,
  input  logic [`I3C_BYTE_W-1:0] ibi_tx_req_value_i,
  input  logic                   ibi_tx_sel_od_pp_i,
  input  logic                   ibi_rx_req_bit_i,
  input  logic                   ibi_rx_req_byte_i,
  output logic                   ibi_tx_done_o,
  output logic                   ibi_rx_done_o,
  output logic [`I3C_BYTE_W-1:0] ibi_rx_data_o,
  // Bus engines
  input  logic                   bus_tx_done_i,
  input  logic                   bus_tx_idle_i,
  input  logic                   bus_tx_err_i,
  input  logic                   bus_rx_done_i,
  input  logic                   bus_rx_idle_i,
  input  logic                   bus_rx_error_i,
  input  logic [`I3C_BYTE_W-1:0] bus_rx_data_i,
  output logic                   bus_tx_req_byte_o,
  output logic                   bus_tx_req_bit_o,
  output logic [`I3C_BYTE_W-1:0] bus_tx_req_value_o,
  output logic                   bus_tx_sel_od_pp_o,
  output logic                   bus_rx_req_bit_o,
  output logic                   bus_rx_req_byte_o,
  // SDA
  input  logic                   tx_sda_i,
  input  logic                   ibi_sda_i,
  output logic                   ctrl_sda_o,
  // Ownership requests
  input  logic                   ccc_valid_i,
  input  logic                   ccc_done_i,
  input  logic                   ccc_next_i,
  input  logic                   ibi_begin_i,
  input  logic                   ibi_done_i,
  // Reset actions
  input  logic [`RSTACT_W-1:0]   rst_action_i,
  input  logic                   rst_action_valid_i,
  input  logic                   target_reset_detect_i,
  input  logic                   escalate_arm_i,
  input  logic                   rstact_armed_i,
  input  logic                   peripheral_reset_done_i,
  output logic                   peripheral_reset_o,
  output logic                   escalated_reset_o
);

  bus_owner_e  owner;
  bus_tx_req_t fsm_tx_req, ccc_tx_req, ibi_tx_req, bus_tx_req;
  bus_rx_req_t fsm_rx_req, ccc_rx_req, ibi_rx_req, bus_rx_req;

  assign fsm_tx_req = '{fsm_tx_req_byte_i, fsm_tx_req_bit_i, fsm_tx_req_value_i,
                        fsm_tx_sel_od_pp_i};
  assign ccc_tx_req = '{ccc_tx_req_byte_i, ccc_tx_req_bit_i, ccc_tx_req_value_i,
                        ccc_tx_sel_od_pp_i};
  assign ibi_tx_req = '{ibi_tx_req_byte_i, ibi_tx_req_bit_i, ibi_tx_req_value_i,
                        ibi_tx_sel_od_pp_i};
  assign fsm_rx_req = '{fsm_rx_req_bit_i, fsm_rx_req_byte_i};
  assign ccc_rx_req = '{ccc_rx_req_bit_i, ccc_rx_req_byte_i};
  assign ibi_rx_req = '{ibi_rx_req_bit_i, ibi_rx_req_byte_i};

  assign bus_tx_req_byte_o  = bus_tx_req.req_byte;
  assign bus_tx_req_bit_o   = bus_tx_req.req_bit;
  assign bus_tx_req_value_o = bus_tx_req.value;
  assign bus_tx_sel_od_pp_o = bus_tx_req.sel_od_pp;
  assign bus_rx_req_bit_o   = bus_rx_req.req_bit;
  assign bus_rx_req_byte_o  = bus_rx_req.req_byte;

  // IBI handler pulls SDA low alongside the TX engine
  assign ctrl_sda_o = tx_sda_i & ibi_sda_i;

  xfer_owner_ctrl u_owner_ctrl (
    .clk_i,
    .rst_ni,
    .ccc_valid_i,
    .ccc_done_i,
    .ccc_next_i,
    .ibi_begin_i,
    .ibi_done_i,
    .owner_o     (owner)
  );

  bus_req_mux #(
    .payload_t (bus_tx_req_t)
  ) u_tx_req_mux (
    .owner_i   (owner),
    .fsm_req_i (fsm_tx_req),
    .ccc_req_i (ccc_tx_req),
    .ibi_req_i (ibi_tx_req),
    .req_o     (bus_tx_req)
  );

  bus_req_mux #(
    .payload_t (bus_rx_req_t)
  ) u_rx_req_mux (
    .owner_i   (owner),
    .fsm_req_i (fsm_rx_req),
    .ccc_req_i (ccc_rx_req),
    .ibi_req_i (ibi_rx_req),
    .req_o     (bus_rx_req)
  );

  bus_rsp_route u_rsp_route (
    .owner_i        (owner),
    .tx_done_i      (bus_tx_done_i),
    .tx_idle_i      (bus_tx_idle_i),
    .tx_err_i       (bus_tx_err_i),
    .rx_done_i      (bus_rx_done_i),
    .rx_idle_i      (bus_rx_idle_i),
    .rx_error_i     (bus_rx_error_i),
    .rx_data_i      (bus_rx_data_i),
    .fsm_tx_done_o,
    .fsm_tx_idle_o,
    .fsm_tx_err_o,
    .fsm_rx_done_o,
    .fsm_rx_idle_o,
    .fsm_rx_error_o,
    .fsm_rx_data_o,
    .ccc_tx_done_o,
    .ccc_tx_idle_o,
    .ccc_tx_err_o,
    .ccc_rx_done_o,
    .ccc_rx_idle_o,
    .ccc_rx_error_o,
    .ccc_rx_data_o,
    .ibi_tx_done_o,
    .ibi_rx_done_o,
    .ibi_rx_data_o
  );

  reset_action_ctrl u_reset_action (
    .clk_i,
    .rst_ni,
    .rst_action_i,
    .rst_action_valid_i,
    .target_reset_detect_i,
    .escalate_arm_i,
    .rstact_armed_i,
    .peripheral_reset_done_i,
    .peripheral_reset_o,
    .escalated_reset_o
  );

endmodule

/* test/standby_bus_asserts.sv */
// Concurrent checks on result routing and reset request registers
`timescale 1ns/1ps

module standby_bus_asserts (
  input logic clk_i,
  input logic rst_ni,
  input logic fsm_tx_done_i,
  input logic ccc_tx_done_i,
  input logic ibi_tx_done_i,
  input logic peripheral_reset_i,
  input logic peripheral_reset_done_i,
  input logic escalated_reset_i
);

  int unsigned fail_count = 0;

  // Only the owner may see a completion
  tx_done_single: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $onehot0({fsm_tx_done_i, ccc_tx_done_i, ibi_tx_done_i}))
    else begin
      fail_count++;
      $error("More than one owner sees tx_done");
    end

  escalated_sticky: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $past(escalated_reset_i) |-> escalated_reset_i)
    else begin
      fail_count++;
      $error("Escalated reset request dropped without a controller reset");
    end

  peripheral_clear: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $fell(peripheral_reset_i) |-> $past(peripheral_reset_done_i))
    else begin
      fail_count++;
      $error("Peripheral reset request cleared without a done pulse");
    end

endmodule

bind standby_bus_top standby_bus_asserts u_asserts (
  .clk_i                   (clk_i),
  .rst_ni                  (rst_ni),
  .fsm_tx_done_i           (fsm_tx_done_o),
  .ccc_tx_done_i           (ccc_tx_done_o),
  .ibi_tx_done_i           (ibi_tx_done_o),
  .peripheral_reset_i      (peripheral_reset_o),
  .peripheral_reset_done_i (peripheral_reset_done_i),
  .escalated_reset_i       (escalated_reset_o)
);

/* test/standby_bus_tb.sv */
// Standby bus glue testbench with random traffic, reference model and per-edge comparison
`timescale 1ns/1ps
`include "standby_macros.svh"

module standby_bus_tb
  import standby_ctrl_pkg::*;
();

  // Tests run about 400 cycles
  localparam int unsigned MAX_CYCLES = 2000;

  typedef struct packed {
    logic [`I3C_BYTE_W+2:0] tx_req;
    logic [1:0]             rx_req;
    logic [`I3C_BYTE_W+5:0] fsm_rsp;
    logic [`I3C_BYTE_W+5:0] ccc_rsp;
    logic [`I3C_BYTE_W+1:0] ibi_rsp;
    logic                   sda;
    logic                   periph;
    logic                   escal;
  } outputs_t;

  logic clk_i;
  logic rst_ni;
  logic fsm_tx_req_byte_i, fsm_tx_req_bit_i, fsm_tx_sel_od_pp_i;
  logic fsm_rx_req_bit_i, fsm_rx_req_byte_i;
  logic [`I3C_BYTE_W-1:0] fsm_tx_req_value_i;
  logic ccc_tx_req_byte_i, ccc_tx_req_bit_i, ccc_tx_sel_od_pp_i;
  logic ccc_rx_req_bit_i, ccc_rx_req_byte_i;
  logic [`I3C_BYTE_W-1:0] ccc_tx_req_value_i;
  logic ibi_tx_req_byte_i, ibi_tx_req_bit_i, ibi_tx_sel_od_pp_i;
  logic ibi_rx_req_bit_i, ibi_rx_req_byte_i;
  logic [`I3C_BYTE_W-1:0] ibi_tx_req_value_i;
  logic fsm_tx_done_o, fsm_tx_idle_o, fsm_tx_err_o;
  logic fsm_rx_done_o, fsm_rx_idle_o, fsm_rx_error_o;
  logic [`I3C_BYTE_W-1:0] fsm_rx_data_o;
  logic ccc_tx_done_o, ccc_tx_idle_o, ccc_tx_err_o;
  logic ccc_rx_done_o, ccc_rx_idle_o, ccc_rx_error_o;
  logic [`I3C_BYTE_W-1:0] ccc_rx_data_o;
  logic ibi_tx_done_o, ibi_rx_done_o;
  logic [`I3C_BYTE_W-1:0] ibi_rx_data_o;
  logic bus_tx_done_i, bus_tx_idle_i, bus_tx_err_i;
  logic bus_rx_done_i, bus_rx_idle_i, bus_rx_error_i;
  logic [`I3C_BYTE_W-1:0] bus_rx_data_i;
  logic bus_tx_req_byte_o, bus_tx_req_bit_o, bus_tx_sel_od_pp_o;
  logic bus_rx_req_bit_o, bus_rx_req_byte_o;
  logic [`I3C_BYTE_W-1:0] bus_tx_req_value_o;
  logic tx_sda_i, ibi_sda_i, ctrl_sda_o;
  logic ccc_valid_i, ccc_done_i, ccc_next_i, ibi_begin_i, ibi_done_i;
  logic [`RSTACT_W-1:0] rst_action_i;
  logic rst_action_valid_i, target_reset_detect_i, escalate_arm_i, rstact_armed_i;
  logic peripheral_reset_done_i, peripheral_reset_o, escalated_reset_o;

  bus_owner_e  model_owner;
  logic        model_periph;
  logic        model_escal;
  outputs_t    exp_out;
  outputs_t    act_out;
  logic [31:0] rng_state = 32'd37994;
  string       test_name = "reset";
  int unsigned check_count;
  int unsigned error_count;
  int unsigned cycle_count;

  standby_bus_top dut (.*);

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  function automatic logic [31:0] rand_word();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  // Expected outputs for a given owner and reset register state
  function automatic outputs_t expected_outputs(input bus_owner_e own, input logic periph,
                                                input logic escal);
    outputs_t               e;
    logic [`I3C_BYTE_W+5:0] engine_rsp;
    e = '0;
    engine_rsp = {bus_tx_done_i, bus_tx_idle_i, bus_tx_err_i, bus_rx_done_i, bus_rx_idle_i,
                  bus_rx_error_i, bus_rx_data_i};
    case (own)
      OwnerFsm: begin
        e.tx_req  = {fsm_tx_req_byte_i, fsm_tx_req_bit_i, fsm_tx_req_value_i, fsm_tx_sel_od_pp_i};
        e.rx_req  = {fsm_rx_req_bit_i, fsm_rx_req_byte_i};
        e.fsm_rsp = engine_rsp;
      end
      OwnerCcc: begin
        e.tx_req  = {ccc_tx_req_byte_i, ccc_tx_req_bit_i, ccc_tx_req_value_i, ccc_tx_sel_od_pp_i};
        e.rx_req  = {ccc_rx_req_bit_i, ccc_rx_req_byte_i};
        e.ccc_rsp = engine_rsp;
      end
      OwnerIbi: begin
        e.tx_req  = {ibi_tx_req_byte_i, ibi_tx_req_bit_i, ibi_tx_req_value_i, ibi_tx_sel_od_pp_i};
        e.rx_req  = {ibi_rx_req_bit_i, ibi_rx_req_byte_i};
        e.ibi_rsp = {bus_tx_done_i, bus_rx_done_i, bus_rx_data_i};
      end
      default: ;
    endcase
    e.sda    = tx_sda_i & ibi_sda_i;
    e.periph = periph;
    e.escal  = escal;
    return e;
  endfunction

  function automatic outputs_t observed_outputs();
    outputs_t o;
    o.tx_req  = {bus_tx_req_byte_o, bus_tx_req_bit_o, bus_tx_req_value_o, bus_tx_sel_od_pp_o};
    o.rx_req  = {bus_rx_req_bit_o, bus_rx_req_byte_o};
    o.fsm_rsp = {fsm_tx_done_o, fsm_tx_idle_o, fsm_tx_err_o, fsm_rx_done_o, fsm_rx_idle_o,
                 fsm_rx_error_o, fsm_rx_data_o};
    o.ccc_rsp = {ccc_tx_done_o, ccc_tx_idle_o, ccc_tx_err_o, ccc_rx_done_o, ccc_rx_idle_o,
                 ccc_rx_error_o, ccc_rx_data_o};
    o.ibi_rsp = {ibi_tx_done_o, ibi_rx_done_o, ibi_rx_data_o};
    o.sda     = ctrl_sda_o;
    o.periph  = peripheral_reset_o;
    o.escal   = escalated_reset_o;
    return o;
  endfunction

  // Ownership and reset registers after one clock edge
  task automatic advance_model();
    logic periph_trig;
    logic escal_trig;
    periph_trig = (rst_action_valid_i && (rst_action_i == `RSTACT_PERIPHERAL)) ||
                  (target_reset_detect_i && !escalate_arm_i && !rstact_armed_i);
    escal_trig  = (rst_action_valid_i && (rst_action_i == `RSTACT_ESCALATE)) ||
                  (target_reset_detect_i && escalate_arm_i && !rstact_armed_i);
    case (model_owner)
      OwnerFsm: begin
        if (ccc_valid_i && !ibi_begin_i) begin
          model_owner = OwnerCcc;
        end else if (ibi_begin_i && !ccc_valid_i) begin
          model_owner = OwnerIbi;
        end
      end
      OwnerCcc: if (ccc_done_i || ccc_next_i) model_owner = OwnerFsm;
      OwnerIbi: if (ibi_done_i) model_owner = OwnerFsm;
      default:  model_owner = OwnerFsm;
    endcase
    if (peripheral_reset_done_i) begin
      model_periph = 1'b0;
    end else if (periph_trig) begin
      model_periph = 1'b1;
    end
    if (escal_trig) begin
      model_escal = 1'b1;
    end
  endtask

  task automatic check_field(input string field, input logic [31:0] exp_val,
                             input logic [31:0] act_val);
    check_count++;
    if (exp_val !== act_val) begin
      error_count++;
      $display("CHECK FAILED %s %s: expected %0h, actual %0h at %0t", test_name, field,
               exp_val, act_val, $time);
    end
  endtask

  always @(posedge clk_i) begin
    if (!rst_ni) begin
      model_owner  = OwnerFsm;
      model_periph = 1'b0;
      model_escal  = 1'b0;
    end else begin
      exp_out = expected_outputs(model_owner, model_periph, model_escal);
      act_out = observed_outputs();
      check_field("bus_tx_req", exp_out.tx_req, act_out.tx_req);
      check_field("bus_rx_req", exp_out.rx_req, act_out.rx_req);
      check_field("fsm_results", exp_out.fsm_rsp, act_out.fsm_rsp);
      check_field("ccc_results", exp_out.ccc_rsp, act_out.ccc_rsp);
      check_field("ibi_results", exp_out.ibi_rsp, act_out.ibi_rsp);
      check_field("ctrl_sda", exp_out.sda, act_out.sda);
      check_field("peripheral_reset", exp_out.periph, act_out.periph);
      check_field("escalated_reset", exp_out.escal, act_out.escal);
      advance_model();
    end
  end

  always @(posedge clk_i) begin
    cycle_count++;
    if (cycle_count >= MAX_CYCLES) begin
      $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
      $display("Done: errors found");
      $finish;
    end
  end

  task automatic randomize_data();
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] c;
    a = rand_word();
    b = rand_word();
    c = rand_word();
    {fsm_tx_req_byte_i, fsm_tx_req_bit_i, fsm_tx_req_value_i, fsm_tx_sel_od_pp_i,
     fsm_rx_req_bit_i, fsm_rx_req_byte_i} = a[12:0];
    {ccc_tx_req_byte_i, ccc_tx_req_bit_i, ccc_tx_req_value_i, ccc_tx_sel_od_pp_i,
     ccc_rx_req_bit_i, ccc_rx_req_byte_i} = a[25:13];
    {ibi_tx_req_byte_i, ibi_tx_req_bit_i, ibi_tx_req_value_i, ibi_tx_sel_od_pp_i,
     ibi_rx_req_bit_i, ibi_rx_req_byte_i} = b[12:0];
    {bus_tx_done_i, bus_tx_idle_i, bus_tx_err_i, bus_rx_done_i, bus_rx_idle_i,
     bus_rx_error_i, bus_rx_data_i} = b[26:13];
    {tx_sda_i, ibi_sda_i} = c[1:0];
  endtask

  task automatic clear_strobes();
    ccc_valid_i             = 1'b0;
    ccc_done_i              = 1'b0;
    ccc_next_i              = 1'b0;
    ibi_begin_i             = 1'b0;
    ibi_done_i              = 1'b0;
    rst_action_valid_i      = 1'b0;
    target_reset_detect_i   = 1'b0;
    peripheral_reset_done_i = 1'b0;
  endtask

  // Falling edge with fresh data and all strobes low
  task automatic next_cycle();
    @(negedge clk_i);
    randomize_data();
    clear_strobes();
  endtask

  task automatic run_cycles(input int n);
    repeat (n) next_cycle();
  endtask

  task automatic random_grants(input int n);
    logic [31:0] r;
    repeat (n) begin
      next_cycle();
      r = rand_word();
      ccc_valid_i = &r[1:0];
      ibi_begin_i = &r[3:2];
      ccc_done_i  = &r[5:4];
      ccc_next_i  = &r[7:6];
      ibi_done_i  = &r[9:8];
    end
  endtask

  initial begin
    rst_ni         = 1'b0;
    rst_action_i   = '0;
    escalate_arm_i = 1'b0;
    rstact_armed_i = 1'b0;
    randomize_data();
    clear_strobes();
    run_cycles(3);
    rst_ni = 1'b1;

    test_name = "fsm_default";
    run_cycles(40);

    test_name = "ccc_grant";
    next_cycle();
    ccc_valid_i = 1'b1;
    run_cycles(10);
    next_cycle();
    ccc_done_i = 1'b1;
    run_cycles(5);
    next_cycle();
    ccc_valid_i = 1'b1;
    run_cycles(8);
    next_cycle();
    ccc_next_i = 1'b1;
    run_cycles(5);

    test_name = "ibi_grant";
    next_cycle();
    ibi_begin_i = 1'b1;
    run_cycles(15);
    next_cycle();
    ibi_done_i = 1'b1;
    run_cycles(5);

    test_name = "grant_conflict";
    next_cycle();
    ccc_valid_i = 1'b1;
    ibi_begin_i = 1'b1;
    run_cycles(4);
    next_cycle();
    ccc_valid_i = 1'b1;
    run_cycles(3);
    // Requests while the CCC handler owns the bus
    next_cycle();
    ibi_begin_i = 1'b1;
    run_cycles(2);
    next_cycle();
    ibi_done_i = 1'b1;
    run_cycles(2);
    next_cycle();
    ccc_valid_i = 1'b1;
    run_cycles(2);
    next_cycle();
    ccc_done_i = 1'b1;
    run_cycles(4);

    test_name = "random_grants";
    random_grants(200);
    next_cycle();
    ccc_done_i = 1'b1;
    ibi_done_i = 1'b1;
    run_cycles(2);

    test_name = "peripheral_reset";
    next_cycle();
    rst_action_i       = `RSTACT_PERIPHERAL;
    rst_action_valid_i = 1'b1;
    run_cycles(4);
    next_cycle();
    peripheral_reset_done_i = 1'b1;
    run_cycles(3);
    next_cycle();
    rstact_armed_i        = 1'b1;
    target_reset_detect_i = 1'b1;
    run_cycles(3);
    next_cycle();
    rstact_armed_i        = 1'b0;
    target_reset_detect_i = 1'b1;
    run_cycles(3);
    // Done and a new trigger in one cycle
    next_cycle();
    peripheral_reset_done_i = 1'b1;
    rst_action_valid_i      = 1'b1;
    run_cycles(3);
    next_cycle();
    rst_action_i       = 8'h03;
    rst_action_valid_i = 1'b1;
    run_cycles(2);

    test_name = "escalated_reset";
    next_cycle();
    rst_action_i       = `RSTACT_ESCALATE;
    rst_action_valid_i = 1'b1;
    run_cycles(3);
    repeat (3) begin
      next_cycle();
      peripheral_reset_done_i = 1'b1;
      run_cycles(2);
    end
    next_cycle();
    rst_ni = 1'b0;
    run_cycles(3);
    rst_ni = 1'b1;
    run_cycles(2);
    next_cycle();
    escalate_arm_i        = 1'b1;
    rstact_armed_i        = 1'b1;
    target_reset_detect_i = 1'b1;
    run_cycles(2);
    next_cycle();
    rstact_armed_i        = 1'b0;
    target_reset_detect_i = 1'b1;
    run_cycles(3);
    next_cycle();
    escalate_arm_i          = 1'b0;
    peripheral_reset_done_i = 1'b1;
    run_cycles(3);

    $display("Checks: %0d, mismatches: %0d, assertion failures: %0d", check_count,
             error_count, dut.u_asserts.fail_count);
    if (error_count == 0 && dut.u_asserts.fail_count == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

/* files.f */
+incdir+logic
logic/i3c_bus_pkg.sv
logic/standby_ctrl_pkg.sv
logic/xfer_owner_ctrl.sv
logic/bus_req_mux.sv
logic/bus_rsp_route.sv
logic/reset_action_ctrl.sv
logic/standby_bus_top.sv
test/standby_bus_asserts.sv
test/standby_bus_tb.sv

/* Bender.yml */
package:
  name: standby_bus

export_include_dirs:
  - logic

sources:
  - include_dirs:
      - logic
    files:
      - logic/i3c_bus_pkg.sv
      - logic/standby_ctrl_pkg.sv
      - logic/xfer_owner_ctrl.sv
      - logic/bus_req_mux.sv
      - logic/bus_rsp_route.sv
      - logic/reset_action_ctrl.sv
      - logic/standby_bus_top.sv
  - target: test
    include_dirs:
      - logic
    files:
      - test/standby_bus_asserts.sv
      - test/standby_bus_tb.sv
